//--- cpuPkg.sv
package cpuPkg;

    // Widths that carry a meaning
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;
    typedef logic [15:0] imm_t;
    typedef logic [25:0] target_t;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,
        OP_J       = 6'd2,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_ADDIU   = 6'd9,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_XORI    = 6'd14,
        OP_LUI     = 6'd15,
        OP_LW      = 6'd35,
        OP_SW      = 6'd43
    } opcode_t;

    // Function codes under SPECIAL
    typedef enum logic [5:0] {
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    // One instruction walks these steps in turn
    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4,
        HALTED    = 3'd5
    } step_t;

    // First fetch address out of reset
    localparam word_t ResetVector = 32'hBFC0_0000;

    localparam int RegCount = 32;

    // Register mirrored on register_v0 at halt
    localparam int ReturnReg = 2;

endpackage

//--- cpuIfs.sv
interface decodedIf;
    import cpuPkg::*;

    opcode_t opcode;
    regIdx_t rs;
    regIdx_t rt;
    regIdx_t rd;
    funct_t  funct;
    imm_t    imm;
    target_t target;
    logic    isLoad;
    logic    isStore;
    logic    isBranch;
    logic    isJump;
    logic    writesRd;

    modport source (output opcode, rs, rt, rd, funct, imm, target,
                    output isLoad, isStore, isBranch, isJump, writesRd);
    modport reader (input opcode, rs, rt, rd, funct, imm,
                    input isLoad, isStore, isBranch, writesRd);
    modport sequencer (input opcode, imm, target, isLoad, isStore, isBranch, isJump);
endinterface

interface memReqIf;
    import cpuPkg::*;

    // Each request is a level held until grantDone
    logic  fetchReq;
    word_t fetchAddr;
    logic  dataRead;
    logic  dataWrite;
    word_t dataAddr;
    word_t dataWrData;
    logic  grantDone;
    word_t rdData;

    modport fetch (output fetchReq, fetchAddr, input grantDone);
    modport decode (input grantDone, rdData);
    modport data (output dataRead, dataWrite, dataAddr, dataWrData, input rdData);
    modport port (input fetchReq, fetchAddr, dataRead, dataWrite, dataAddr, dataWrData,
                  output grantDone, rdData);
endinterface

//--- busPort.sv
module busPort (
    input  logic           clk,
    input  logic           reset,
    memReqIf.port          mem,
    output cpuPkg::word_t  address,
    output logic           read,
    output logic           write,
    output cpuPkg::word_t  writedata,
    output logic [3:0]     byteenable,
    input  logic           waitrequest,
    input  cpuPkg::word_t  readdata
);
    import cpuPkg::*;

    word_t rdHold;
    logic  completing;
    logic  readDone;

    // Fetch and data requests are never live in the same cycle
    assign read      = mem.fetchReq | mem.dataRead;
    assign write     = mem.dataWrite;
    assign address   = mem.fetchReq ? mem.fetchAddr : mem.dataAddr;
    assign writedata = mem.dataWrData;

    // Word accesses only
    assign byteenable = 4'b1111;

    // Requesters hold their level, so the bus stays stable under waitrequest
    assign completing = (read | write) & ~waitrequest;
    assign readDone   = completing & read;

    assign mem.grantDone = completing;

    // Forward readdata in the completing cycle, then keep it
    assign mem.rdData = readDone ? readdata : rdHold;

    always_ff @(posedge clk) begin
        if (reset) begin
            rdHold <= '0;
        end else if (readDone) begin
            rdHold <= readdata;
        end
    end

endmodule

//--- registerFile.sv
module registerFile (
    input  logic             clk,
    input  logic             reset,
    input  cpuPkg::step_t    step,
    decodedIf.reader         dec,
    input  logic             writeEnable,
    input  cpuPkg::regIdx_t  writeIdx,
    input  cpuPkg::word_t    writeData,
    output cpuPkg::word_t    rsValue,
    output cpuPkg::word_t    rtValue,
    output cpuPkg::word_t    v0Value
);
    import cpuPkg::*;

    word_t regs [RegCount];

    assign rsValue = regs[dec.rs];
    assign rtValue = regs[dec.rt];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
            v0Value <= '0;
        end else begin
            // Register zero stays hardwired to zero
            if (writeEnable && writeIdx != '0) begin
                regs[writeIdx] <= writeData;
            end
            // Nothing writes once halted, so v0 settles here
            if (step == HALTED) begin
                v0Value <= regs[ReturnReg];
            end
        end
    end

endmodule

//--- instructionDecode.sv
module instructionDecode (
    input  logic           clk,
    input  logic           reset,
    input  cpuPkg::step_t  step,
    memReqIf.decode        mem,
    decodedIf.source       dec
);
    import cpuPkg::*;

    word_t instrReg;
    logic  isSpecial;

    always_ff @(posedge clk) begin
        if (reset) begin
            instrReg <= '0;
        end else if (step == FETCH && mem.grantDone) begin
            instrReg <= mem.rdData;
        end
    end

    // Field split
    assign dec.opcode = opcode_t'(instrReg[31:26]);
    assign dec.rs     = instrReg[25:21];
    assign dec.rt     = instrReg[20:16];
    assign dec.rd     = instrReg[15:11];
    assign dec.funct  = funct_t'(instrReg[5:0]);
    assign dec.imm    = instrReg[15:0];
    assign dec.target = instrReg[25:0];

    assign isSpecial = dec.opcode == OP_SPECIAL;

    // Instruction class, decided here only
    assign dec.isLoad   = dec.opcode == OP_LW;
    assign dec.isStore  = dec.opcode == OP_SW;
    assign dec.isBranch = dec.opcode == OP_BEQ || dec.opcode == OP_BNE;
    assign dec.isJump   = dec.opcode == OP_J || (isSpecial && dec.funct == FN_JR);

    // R-type results land in rd, everything else in rt
    assign dec.writesRd = isSpecial;

endmodule

//--- executeUnit.sv
module executeUnit (
    input  logic             clk,
    input  logic             reset,
    input  cpuPkg::step_t    step,
    decodedIf.reader         dec,
    input  cpuPkg::word_t    rsValue,
    input  cpuPkg::word_t    rtValue,
    memReqIf.data            mem,
    output logic             branchTaken,
    output logic             writeEnable,
    output cpuPkg::regIdx_t  writeIdx,
    output cpuPkg::word_t    writeData
);
    import cpuPkg::*;

    word_t immSext;
    word_t immZext;
    word_t aluOut;
    word_t aluResult;

    assign immSext = {{16{dec.imm[15]}}, dec.imm};
    assign immZext = {16'h0000, dec.imm};

    always_comb begin
        aluOut = '0;
        case (dec.opcode)
            OP_SPECIAL: begin
                case (dec.funct)
                    FN_ADDU: aluOut = rsValue + rtValue;
                    FN_SUBU: aluOut = rsValue - rtValue;
                    FN_AND:  aluOut = rsValue & rtValue;
                    FN_OR:   aluOut = rsValue | rtValue;
                    FN_XOR:  aluOut = rsValue ^ rtValue;
                    FN_SLT:  aluOut = {31'b0, $signed(rsValue) < $signed(rtValue)};
                    FN_SLTU: aluOut = {31'b0, rsValue < rtValue};
                    default: aluOut = '0;
                endcase
            end
            // Loads and stores share the ADDIU adder for their address
            OP_ADDIU, OP_LW, OP_SW: aluOut = rsValue + immSext;
            OP_ANDI: aluOut = rsValue & immZext;
            OP_ORI:  aluOut = rsValue | immZext;
            OP_XORI: aluOut = rsValue ^ immZext;
            OP_LUI:  aluOut = {dec.imm, 16'h0000};
            default: aluOut = '0;
        endcase
    end

    // BEQ taken on equal, BNE on not equal
    assign branchTaken = dec.isBranch && ((dec.opcode == OP_BEQ) == (rsValue == rtValue));

    always_ff @(posedge clk) begin
        if (reset) begin
            aluResult <= '0;
        end else if (step == EXECUTE) begin
            aluResult <= aluOut;
        end
    end

    assign mem.dataRead   = step == MEMORY && dec.isLoad;
    assign mem.dataWrite  = step == MEMORY && dec.isStore;
    assign mem.dataAddr   = {aluResult[31:2], 2'b00};
    assign mem.dataWrData = rtValue;

    assign writeEnable = step == WRITEBACK;
    assign writeIdx    = dec.writesRd ? dec.rd : dec.rt;
    assign writeData   = dec.isLoad ? mem.rdData : aluResult;

endmodule

//--- cpuSequencer.sv
module cpuSequencer (
    input  logic           clk,
    input  logic           reset,
    decodedIf.sequencer    dec,
    memReqIf.fetch         mem,
    input  logic           branchTaken,
    input  cpuPkg::word_t  rsValue,
    output cpuPkg::step_t  step,
    output cpuPkg::word_t  pc,
    output logic           active
);
    import cpuPkg::*;

    logic  fetchPending;
    logic  haltJump;
    word_t pcPlus4;
    word_t branchTarget;
    word_t jumpTarget;
    word_t nextPc;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{dec.imm[15]}}, dec.imm, 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], dec.target, 2'b00};

    // JR to address zero ends the program
    assign haltJump = dec.isJump && dec.opcode == OP_SPECIAL && rsValue == '0;

    always_comb begin
        nextPc = pcPlus4;
        if (dec.isJump) begin
            nextPc = (dec.opcode == OP_J) ? jumpTarget : rsValue;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end
    end

    assign mem.fetchReq  = fetchPending;
    assign mem.fetchAddr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            step         <= FETCH;
            pc           <= ResetVector;
            fetchPending <= 1'b0;
            active       <= 1'b1;
        end else begin
            case (step)
                FETCH: begin
                    // First fetch after reset raises the request one cycle late
                    if (!fetchPending) begin
                        fetchPending <= 1'b1;
                    end else if (mem.grantDone) begin
                        fetchPending <= 1'b0;
                        step         <= DECODE;
                    end
                end
                DECODE: step <= EXECUTE;
                EXECUTE: begin
                    if (haltJump) begin
                        step   <= HALTED;
                        active <= 1'b0;
                    end else if (dec.isBranch || dec.isJump) begin
                        pc           <= nextPc;
                        fetchPending <= 1'b1;
                        step         <= FETCH;
                    end else if (dec.isLoad || dec.isStore) begin
                        step <= MEMORY;
                    end else begin
                        step <= WRITEBACK;
                    end
                end
                MEMORY: begin
                    if (mem.grantDone && dec.isLoad) begin
                        step <= WRITEBACK;
                    end else if (mem.grantDone) begin
                        pc           <= nextPc;
                        fetchPending <= 1'b1;
                        step         <= FETCH;
                    end
                end
                WRITEBACK: begin
                    pc           <= nextPc;
                    fetchPending <= 1'b1;
                    step         <= FETCH;
                end
                default: step <= HALTED;
            endcase
        end
    end

endmodule

//--- mipsCpuBus.sv
module mipsCpuBus (
    input  logic           clk,
    input  logic           reset,
    output logic           active,
    output cpuPkg::word_t  register_v0,
    output cpuPkg::word_t  address,
    output logic           write,
    output logic           read,
    input  logic           waitrequest,
    output cpuPkg::word_t  writedata,
    output logic [3:0]     byteenable,
    input  cpuPkg::word_t  readdata
);
    import cpuPkg::*;

    step_t   step;
    word_t   rsValue;
    word_t   rtValue;
    logic    branchTaken;
    logic    writeEnable;
    regIdx_t writeIdx;
    word_t   writeData;

    decodedIf dec ();
    memReqIf  mem ();

    cpuSequencer u_sequencer (
        .clk(clk),
        .reset(reset),
        .dec(dec.sequencer),
        .mem(mem.fetch),
        .branchTaken(branchTaken),
        .rsValue(rsValue),
        .step(step),
        .pc(),
        .active(active)
    );

    instructionDecode u_decode (
        .clk(clk),
        .reset(reset),
        .step(step),
        .mem(mem.decode),
        .dec(dec.source)
    );

    // v0 capture on halt happens inside the register file
    registerFile u_regFile (
        .clk(clk),
        .reset(reset),
        .step(step),
        .dec(dec.reader),
        .writeEnable(writeEnable),
        .writeIdx(writeIdx),
        .writeData(writeData),
        .rsValue(rsValue),
        .rtValue(rtValue),
        .v0Value(register_v0)
    );

    executeUnit u_execute (
        .clk(clk),
        .reset(reset),
        .step(step),
        .dec(dec.reader),
        .rsValue(rsValue),
        .rtValue(rtValue),
        .mem(mem.data),
        .branchTaken(branchTaken),
        .writeEnable(writeEnable),
        .writeIdx(writeIdx),
        .writeData(writeData)
    );

    busPort u_busPort (
        .clk(clk),
        .reset(reset),
        .mem(mem.port),
        .address(address),
        .read(read),
        .write(write),
        .writedata(writedata),
        .byteenable(byteenable),
        .waitrequest(waitrequest),
        .readdata(readdata)
    );

endmodule

//--- cpuBus_asserts.sv
module cpuBusAsserts (
    input logic           clk,
    input logic           reset,
    input logic           active,
    input logic           read,
    input logic           write,
    input logic           waitrequest,
    input cpuPkg::word_t  address,
    input cpuPkg::word_t  writedata
);
    timeunit 1ns;
    timeprecision 1ps;

    // One direction per access
    noBothAccess: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else $error("read and write high in the same cycle");

    // A stalled access keeps its request
    stallHolds: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read)
            && $stable(write) && $stable(writedata))
        else $error("bus request changed while waitrequest was high");

    quietWhenHalted: assert property (@(posedge clk) disable iff (reset)
        !active |-> !read && !write)
        else $error("bus access after the CPU halted");

endmodule

bind mipsCpuBus cpuBusAsserts u_busAsserts (.*);

//--- tbCpuModel.sv
module tbCpuModel;
    timeunit 1ns;
    timeprecision 1ps;
    import cpuPkg::*;

    localparam int    ProgWords = 64;
    localparam int    DataWords = 64;
    localparam word_t DataBase  = 32'h0000_1000;

    word_t prog [ProgWords];
    word_t data [DataWords];
    word_t regs [RegCount];
    word_t pc;

    task automatic clearState();
        pc = ResetVector;
        for (int i = 0; i < RegCount; i++) begin
            regs[i] = '0;
        end
    endtask

    // One whole instruction per call, no delay slots
    task automatic executeNext(output word_t fetchPc, output logic stored,
                               output word_t stAddr, output word_t stData,
                               output logic halted);
        word_t      instr;
        word_t      a;
        word_t      b;
        word_t      se;
        word_t      ze;
        word_t      next;
        word_t      res;
        logic [5:0] op;
        regIdx_t    dst;
        logic       wr;
        instr   = prog[(pc - ResetVector) >> 2];
        op      = instr[31:26];
        a       = regs[instr[25:21]];
        b       = regs[instr[20:16]];
        se      = {{16{instr[15]}}, instr[15:0]};
        ze      = {16'h0000, instr[15:0]};
        fetchPc = pc;
        stored  = 1'b0;
        stAddr  = '0;
        stData  = '0;
        halted  = 1'b0;
        next    = pc + 32'd4;
        res     = '0;
        wr      = 1'b1;
        dst     = instr[20:16];
        case (op)
            OP_SPECIAL: begin
                dst = instr[15:11];
                case (instr[5:0])
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                    FN_JR: begin
                        wr     = 1'b0;
                        next   = a;
                        halted = (a == '0);
                    end
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDIU: res = a + se;
            OP_ANDI:  res = a & ze;
            OP_ORI:   res = a | ze;
            OP_XORI:  res = a ^ ze;
            OP_LUI:   res = {instr[15:0], 16'h0000};
            OP_LW:    res = data[(a + se - DataBase) >> 2];
            OP_SW: begin
                wr     = 1'b0;
                stored = 1'b1;
                stAddr = a + se;
                stData = b;
                data[(stAddr - DataBase) >> 2] = b;
            end
            OP_BEQ, OP_BNE: begin
                wr = 1'b0;
                if ((op == OP_BEQ) ? (a == b) : (a != b)) begin
                    next = pc + 32'd4 + (se << 2);
                end
            end
            // Region bits come from the address after the jump
            OP_J: begin
                wr   = 1'b0;
                next = {next[31:28], instr[25:0], 2'b00};
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != '0) begin
            regs[dst] = res;
        end
        pc = next;
    endtask

endmodule

//--- tbMipsCpu.sv
module tbMipsCpu;
    timeunit 1ns;
    timeprecision 1ps;
    import cpuPkg::*;

    localparam int          ProgLen       = 40;
    localparam int          DataWords     = 64;
    localparam word_t       DataBase      = 32'h0000_1000;
    localparam int          TimeoutCycles = ProgLen * 5 * 4 * 2;
    localparam int          MaxAccesses   = 2 * ProgLen;
    localparam logic [31:0] Seed          = 32'hc98fd4ed;

    logic       clk;
    logic       reset;
    logic       active;
    word_t      register_v0;
    word_t      address;
    logic       read;
    logic       write;
    logic       waitrequest;
    word_t      writedata;
    logic [3:0] byteenable;
    word_t      readdata;

    word_t   progMem [ProgLen];
    word_t   dataMem [DataWords];
    word_t   expFetch [$];
    word_t   expWrAddr [$];
    word_t   expWrData [$];
    word_t   expV0;
    word_t   heldAddr;
    word_t   heldData;
    logic [1:0] heldCtl;
    logic    holding;
    logic    inAccess;
    int      waitLeft;
    int      waitPlan [MaxAccesses];
    int      accessCount;
    int      errors;
    int      cycles = 0;
    funct_t  aluFuncts [7] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU};
    opcode_t immOps [5] = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};

    mipsCpuBus u_mipsCpuBus (.*);

    tbCpuModel u_model ();

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic checkValue(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            errors++;
            $display("mismatch: %s got 0x%h expected 0x%h", name, got, expected);
        end
    endtask

    function automatic word_t fillWord(input word_t addr);
        return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic regIdx_t pickReg();
        return regIdx_t'(1 + $urandom % 7);
    endfunction

    function automatic word_t encodeR(input logic [5:0] fn, input regIdx_t rs,
                                      input regIdx_t rt, input regIdx_t rd);
        return {6'd0, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t encodeI(input logic [5:0] op, input regIdx_t rs,
                                      input regIdx_t rt, input imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic buildProgram();
        int    off;
        word_t target;
        for (int k = 0; k < DataWords; k++) begin
            dataMem[k] = fillWord(DataBase + 4 * k);
            u_model.data[k] = dataMem[k];
        end
        for (int i = 0; i < ProgLen - 2; i++) begin
            // Forward only and never past the final JR
            off = $urandom % 4;
            if (i + 1 + off > ProgLen - 1) begin
                off = ProgLen - 2 - i;
            end
            target = ResetVector + 4 * (i + 1 + off);
            case ($urandom % 12)
                0, 1, 2, 3: progMem[i] = encodeR(aluFuncts[$urandom % 7], pickReg(),
                                                 pickReg(), pickReg());
                4, 5, 6: progMem[i] = encodeI(immOps[$urandom % 5], pickReg(), pickReg(),
                                              imm_t'($urandom));
                7: progMem[i] = encodeI(OP_LW, 5'd0, pickReg(),
                                        imm_t'(DataBase + 4 * ($urandom % DataWords)));
                8, 9: progMem[i] = encodeI(OP_SW, 5'd0, pickReg(),
                                           imm_t'(DataBase + 4 * ($urandom % DataWords)));
                10: progMem[i] = encodeI(($urandom % 2) ? OP_BEQ : OP_BNE, pickReg(),
                                         pickReg(), imm_t'(off));
                default: progMem[i] = {OP_J, target[27:2]};
            endcase
        end
        progMem[ProgLen - 2] = encodeI(OP_ORI, pickReg(), 5'd2, imm_t'($urandom));
        progMem[ProgLen - 1] = encodeR(FN_JR, 5'd0, 5'd0, 5'd0);
    endtask

    // Expected fetch and write order from the reference model
    task automatic runModel();
        word_t fetchPc;
        word_t stAddr;
        word_t stData;
        logic  stored;
        logic  halted;
        int    n;
        for (int i = 0; i < ProgLen; i++) begin
            u_model.prog[i] = progMem[i];
        end
        u_model.clearState();
        halted = 1'b0;
        n = 0;
        while (!halted && n < 4 * ProgLen) begin
            u_model.executeNext(fetchPc, stored, stAddr, stData, halted);
            expFetch.push_back(fetchPc);
            if (stored) begin
                expWrAddr.push_back(stAddr);
                expWrData.push_back(stData);
            end
            n++;
        end
        expV0 = u_model.regs[ReturnReg];
    endtask

    function automatic word_t memRead(input word_t addr);
        word_t idx;
        idx = (addr - ResetVector) >> 2;
        if (addr[31:8] == DataBase[31:8]) begin
            return dataMem[addr[7:2]];
        end else if (idx < ProgLen) begin
            return progMem[idx];
        end
        return fillWord(addr);
    endfunction

    task automatic sampleBus();
        if (read && write) begin
            errors++;
            $display("read and write were high together at address %h", address);
        end
        if (!active && (read || write)) begin
            errors++;
            $display("bus access at address %h after the CPU halted", address);
        end
        if (holding) begin
            checkValue("address", address, heldAddr);
            checkValue("writedata", writedata, heldData);
            checkValue("read/write", {read, write}, heldCtl);
        end
        holding  = (read || write) && waitrequest;
        heldAddr = address;
        heldData = writedata;
        heldCtl  = {read, write};
        if ((read || write) && waitrequest) begin
            waitLeft--;
        end else if (read || write) begin
            inAccess = 1'b0;
            checkValue("byteenable", byteenable, 32'hF);
            if (write) begin
                if (expWrAddr.size() == 0) begin
                    errors++;
                    $display("write to %h that the model does not expect", address);
                end else begin
                    checkValue("write address", address, expWrAddr.pop_front());
                    checkValue("writedata", writedata, expWrData.pop_front());
                end
                dataMem[address[7:2]] = writedata;
            end else if (address[31:8] != DataBase[31:8]) begin
                if (expFetch.size() == 0) begin
                    errors++;
                    $display("fetch at %h after the program should have ended", address);
                end else begin
                    checkValue("fetch address", address, expFetch.pop_front());
                end
            end
        end
    endtask

    // New access gets 0 to 3 wait cycles
    task automatic driveBus();
        if (reset) begin
            waitrequest = 1'b0;
            readdata    = '0;
        end else begin
            if ((read || write) && !inAccess) begin
                inAccess = 1'b1;
                waitLeft = waitPlan[accessCount % MaxAccesses];
                accessCount++;
            end
            waitrequest = (read || write) && waitLeft != 0;
            readdata    = read ? memRead(address) : '0;
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            sampleBus();
        end
        #1;
        driveBus();
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TimeoutCycles) begin
            $display("timeout: the CPU did not halt within %0d cycles", TimeoutCycles);
            $display("errors: %0d", errors);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(Seed));
        reset       = 1'b1;
        waitrequest = 1'b0;
        readdata    = '0;
        errors      = 0;
        holding     = 1'b0;
        inAccess    = 1'b0;
        waitLeft    = 0;
        accessCount = 0;
        buildProgram();
        for (int k = 0; k < MaxAccesses; k++) begin
            waitPlan[k] = $urandom % 4;
        end
        runModel();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        checkValue("active", active, 32'd1);
        checkValue("read", read, 32'd0);
        checkValue("write", write, 32'd0);
        checkValue("register_v0", register_v0, 32'd0);
        wait (!active);
        // v0 is captured one cycle into HALTED
        repeat (4) @(posedge clk);
        checkValue("register_v0", register_v0, expV0);
        if (expFetch.size() != 0 || expWrAddr.size() != 0) begin
            errors++;
            $display("%0d fetches and %0d writes of the model never reached the bus",
                     expFetch.size(), expWrAddr.size());
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
cpuPkg.sv
cpuIfs.sv
busPort.sv
registerFile.sv
instructionDecode.sv
executeUnit.sv
cpuSequencer.sv
mipsCpuBus.sv
cpuBus_asserts.sv
tbCpuModel.sv
tbMipsCpu.sv
